// File: hdl/uart_bus_pkg.sv
`default_nettype none

package uart_bus_pkg;

    // width of the data bus.
    localparam int xlen = 64;

    // request from the core side, held steady until ready.
    typedef struct packed {
        logic            valid; // request present.
        logic            store; // write when set, blocking read when clear.
        logic [xlen-1:0] wdata; // only the low byte is sent.
    } bus_request_t;

    // response to the core side.
    typedef struct packed {
        logic [xlen-1:0] rdata; // received byte, zero-extended.
        logic            ready; // one-cycle completion pulse.
    } bus_response_t;

endpackage

`default_nettype wire

// File: hdl/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

    localparam int data_bits = 8;

    // start + data + stop, 8N1.
    localparam int frame_bits = 10;

    // levels on the serial line.
    localparam logic line_idle = 1'b1;
    localparam logic start_bit = 1'b0;
    localparam logic stop_bit = 1'b1;

    typedef logic [data_bits-1:0] line_byte_t;

endpackage

`default_nettype wire

// File: hdl/uart_bus_port.sv
`default_nettype none

module uart_bus_port (
    input  logic                        clock,
    input  logic                        reset,
    input  uart_bus_pkg::bus_request_t  request,
    output uart_bus_pkg::bus_response_t response,
    output logic                        tx_start,
    output uart_line_pkg::line_byte_t   tx_byte,
    input  logic                        tx_busy,
    input  logic                        tx_done,
    input  uart_line_pkg::line_byte_t   rx_byte,
    input  logic                        rx_strobe
);

    logic store_issued; // frame started for the current store.
    logic load_pending; // read waiting for the next byte.
    logic store_complete;
    logic load_complete;
    logic load_request;

    // one start per held store request.
    assign tx_start = request.valid & request.store & ~store_issued & ~tx_busy;
    assign tx_byte = request.wdata[uart_line_pkg::data_bits-1:0];

    assign store_complete = store_issued & tx_done;
    assign load_complete = load_pending & rx_strobe;

    // the ready cycle still sees valid, so it must not open a new load.
    assign load_request = request.valid & ~request.store & ~load_pending & ~response.ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            store_issued <= 1'b0;
        end else if (tx_start) begin
            store_issued <= 1'b1;
        end else if (response.ready) begin
            store_issued <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            load_pending <= 1'b0;
        end else if (load_complete) begin
            load_pending <= 1'b0;
        end else if (load_request) begin
            load_pending <= 1'b1; // a strobe in this same cycle is not counted.
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            response <= '0;
        end else begin
            response.ready <= store_complete | load_complete;
            if (load_complete) begin
                response.rdata <= {{(uart_bus_pkg::xlen - uart_line_pkg::data_bits){1'b0}},
                                   rx_byte};
            end else if (store_complete) begin
                response.rdata <= '0;
            end
        end
    end

    ready_single_cycle: assert property (
        @(posedge clock) disable iff (!reset)
        response.ready |=> !response.ready
    ) else $error("ready held for more than one cycle.");

endmodule

`default_nettype wire

// File: hdl/uart_transmitter.sv
`default_nettype none

module uart_transmitter #(
    parameter int clks_per_bit = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      tx_start,
    input  uart_line_pkg::line_byte_t tx_byte,
    output logic                      tx_busy,
    output logic                      tx_done,
    output logic                      tx
);

    localparam int count_width = $clog2(clks_per_bit);
    localparam logic [count_width-1:0] last_count = count_width'(clks_per_bit - 1);
    localparam logic [3:0] last_bit = 4'(uart_line_pkg::frame_bits - 1);

    logic [uart_line_pkg::frame_bits-1:0] shift; // bit 0 is on the line.
    logic [count_width-1:0]               clk_count;
    logic [3:0]                           bit_count;
    logic                                 bit_end;

    assign bit_end = tx_busy && (clk_count == last_count);

    // last cycle of the stop bit.
    assign tx_done = bit_end && (bit_count == last_bit);

    assign tx = shift[0]; // straight from a flop.

    always_ff @(posedge clock) begin
        if (!reset) begin
            shift <= {uart_line_pkg::frame_bits{uart_line_pkg::line_idle}};
            tx_busy <= 1'b0;
        end else if (tx_start && !tx_busy) begin
            shift <= {uart_line_pkg::stop_bit, tx_byte, uart_line_pkg::start_bit};
            tx_busy <= 1'b1;
        end else if (bit_end) begin
            shift <= {uart_line_pkg::line_idle, shift[uart_line_pkg::frame_bits-1:1]};
            if (bit_count == last_bit) begin
                tx_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            clk_count <= '0;
            bit_count <= '0;
        end else if (tx_start && !tx_busy) begin
            clk_count <= '0;
            bit_count <= '0;
        end else if (bit_end) begin
            clk_count <= '0;
            bit_count <= bit_count + 4'd1;
        end else if (tx_busy) begin
            clk_count <= clk_count + count_width'(1);
        end
    end

    // a new frame may only be requested once the one in flight has ended.
    start_when_idle: assert property (
        @(posedge clock) disable iff (!reset)
        tx_start |-> !tx_busy
    ) else $error("tx_start arrived while the transmitter is busy.");

endmodule

`default_nettype wire

// File: hdl/uart_receiver.sv
`default_nettype none

module uart_receiver #(
    parameter int clks_per_bit = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      rx,
    output uart_line_pkg::line_byte_t rx_byte,
    output logic                      rx_strobe
);

    localparam int count_width = $clog2(clks_per_bit);
    localparam logic [count_width-1:0] last_count = count_width'(clks_per_bit - 1);
    localparam logic [count_width-1:0] half_count = count_width'(clks_per_bit / 2 - 1);
    localparam logic [2:0] last_data = 3'(uart_line_pkg::data_bits - 1);

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } state_t;

    state_t                 state;
    logic [1:0]             sync;
    logic                   rx_sync;
    logic [count_width-1:0] clk_count;
    logic [2:0]             bit_index;

    assign rx_sync = sync[1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            sync <= {2{uart_line_pkg::line_idle}};
        end else begin
            sync <= {sync[0], rx};
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            clk_count <= '0;
            bit_index <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                idle: begin
                    if (rx_sync == uart_line_pkg::start_bit) begin
                        state <= start;
                        clk_count <= count_width'(1); // the detect cycle counts.
                    end
                end
                start: begin
                    if (clk_count == half_count) begin
                        clk_count <= '0;
                        bit_index <= '0;
                        // high again at mid-bit is a glitch.
                        state <= (rx_sync == uart_line_pkg::start_bit) ? data : idle;
                    end else begin
                        clk_count <= clk_count + count_width'(1);
                    end
                end
                data: begin
                    if (clk_count == last_count) begin
                        clk_count <= '0;
                        bit_index <= bit_index + 3'd1;
                        if (bit_index == last_data) begin
                            state <= stop;
                        end
                    end else begin
                        clk_count <= clk_count + count_width'(1);
                    end
                end
                default: begin
                    if (clk_count == last_count) begin
                        clk_count <= '0;
                        state <= idle;
                        rx_strobe <= (rx_sync == uart_line_pkg::stop_bit); // framing check.
                    end else begin
                        clk_count <= clk_count + count_width'(1);
                    end
                end
            endcase
        end
    end

    // data arrives lsb first, so shift in from the top.
    always_ff @(posedge clock) begin
        if (state == data && clk_count == last_count) begin
            rx_byte <= {rx_sync, rx_byte[uart_line_pkg::data_bits-1:1]};
        end
    end

    strobe_single_cycle: assert property (
        @(posedge clock) disable iff (!reset)
        rx_strobe |=> !rx_strobe
    ) else $error("rx_strobe held for more than one cycle.");

endmodule

`default_nettype wire

// File: hdl/uart.sv
`default_nettype none

module uart #(
    parameter int clks_per_bit = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  uart_bus_pkg::bus_request_t  request,
    output uart_bus_pkg::bus_response_t response,
    input  logic                        rx,
    output logic                        tx
);

    logic                      tx_start;
    uart_line_pkg::line_byte_t tx_byte;
    logic                      tx_busy;
    logic                      tx_done;
    uart_line_pkg::line_byte_t rx_byte;
    logic                      rx_strobe;

    uart_bus_port u_bus_port (
        .clock     (clock),
        .reset     (reset),
        .request   (request),
        .response  (response),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx_busy   (tx_busy),
        .tx_done   (tx_done),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    uart_transmitter #(
        .clks_per_bit (clks_per_bit)
    ) u_transmitter (
        .clock    (clock),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done),
        .tx       (tx)
    );

    uart_receiver #(
        .clks_per_bit (clks_per_bit)
    ) u_receiver (
        .clock     (clock),
        .reset     (reset),
        .rx        (rx),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

endmodule

`default_nettype wire

// File: verification/uart_line_model.sv
`default_nettype none

module uart_line_model #(
    parameter int clks_per_bit = 8
) (
    input  logic clock,
    input  logic tx,
    output logic rx
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int capture_timeout = 4 * uart_line_pkg::frame_bits * clks_per_bit;

    initial rx = uart_line_pkg::line_idle;

    // one 8N1 frame on rx, levels change on the falling edge.
    task automatic send_frame(input uart_line_pkg::line_byte_t value);
        logic [uart_line_pkg::frame_bits-1:0] frame;
        int i;
        frame = {uart_line_pkg::stop_bit, value, uart_line_pkg::start_bit};
        @(negedge clock);
        for (i = 0; i < uart_line_pkg::frame_bits; i++) begin
            rx = frame[i];
            repeat (clks_per_bit) @(negedge clock);
        end
    endtask

    // short low pulse that looks like the start of a frame.
    task automatic send_glitch(input int low_cycles);
        @(negedge clock);
        rx = uart_line_pkg::start_bit;
        repeat (low_cycles) @(negedge clock);
        rx = uart_line_pkg::line_idle;
    endtask

    // decodes one frame from tx, every bit sampled on each of its cycles.
    task automatic capture_frame(
        output uart_line_pkg::line_byte_t value,
        output int                        idle_cycles,
        output string                     problem
    );
        logic [uart_line_pkg::frame_bits-1:0] bits;
        logic level;
        int i;
        int j;
        problem = "";
        value = '0;
        idle_cycles = 0;
        @(negedge clock);
        while (tx !== uart_line_pkg::start_bit) begin
            if (idle_cycles >= capture_timeout) begin
                problem = "timeout: no start bit seen on tx";
                return;
            end
            idle_cycles++;
            @(negedge clock);
        end
        for (i = 0; i < uart_line_pkg::frame_bits; i++) begin
            level = tx;
            bits[i] = level;
            for (j = 1; j < clks_per_bit; j++) begin
                @(negedge clock);
                if (tx !== level && problem == "") begin
                    problem = $sformatf("tx changed inside bit period %0d", i);
                end
            end
            @(negedge clock);
        end
        if (problem == "" && bits[uart_line_pkg::frame_bits-1] !== uart_line_pkg::stop_bit) begin
            problem = "stop bit on tx was low";
        end
        value = bits[uart_line_pkg::data_bits:1];
    endtask

endmodule

`default_nettype wire

// File: verification/tb_uart.sv
`default_nettype none

module tb_uart;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clks_per_bit = 8;
    localparam int store_latency = uart_line_pkg::frame_bits * clks_per_bit + 1;
    localparam int ready_timeout = 4 * uart_line_pkg::frame_bits * clks_per_bit;

    logic                        clock;
    logic                        reset;
    uart_bus_pkg::bus_request_t  request;
    uart_bus_pkg::bus_response_t response;
    logic                        rx;
    logic                        tx;
    logic                        request_seen; // set by the first bus request.
    uart_line_pkg::line_byte_t   dropped;
    uart_line_pkg::line_byte_t   kept;

    uart #(
        .clks_per_bit (clks_per_bit)
    ) u_dut (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .response (response),
        .rx       (rx),
        .tx       (tx)
    );

    uart_line_model #(
        .clks_per_bit (clks_per_bit)
    ) u_line (
        .clock (clock),
        .tx    (tx),
        .rx    (rx)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic report_failure(input string what);
        $display(">>> FAIL");
        $display("%s", what);
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else report_failure($sformatf(
            "Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual));
    endtask

    task automatic present_request(input logic store, input uart_line_pkg::line_byte_t value);
        request.valid = 1'b1;
        request.store = store;
        request.wdata = {$urandom, $urandom}; // upper bits must not matter.
        request.wdata[uart_line_pkg::data_bits-1:0] = value;
        request_seen = 1'b1;
    endtask

    task automatic wait_for_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > ready_timeout) report_failure("timeout: no ready from the DUT");
        end while (!response.ready);
    endtask

    task automatic expect_no_ready(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_value("response.ready", 64'd0, 64'(response.ready));
        end
    endtask

    task automatic store_byte(input uart_line_pkg::line_byte_t value, input bit back_to_back);
        uart_line_pkg::line_byte_t seen;
        int idle;
        int cycles;
        string problem;
        if (back_to_back) begin
            @(negedge clock); // the cycle after ready.
        end
        present_request(1'b1, value);
        fork
            u_line.capture_frame(seen, idle, problem);
            begin
                wait_for_ready(cycles);
                check_value("store ready latency", 64'(store_latency), 64'(cycles));
                request = '0;
            end
        join
        if (problem != "") report_failure(problem);
        check_value("tx data byte", 64'(value), 64'(seen));
        // start bit follows the first cycle of the request.
        check_value("tx start bit delay", 64'd0, 64'(idle));
    endtask

    task automatic load_byte(input uart_line_pkg::line_byte_t value, input int lead,
                             input int glitch_cycles);
        int cycles;
        present_request(1'b0, 8'h00);
        if (glitch_cycles > 0) u_line.send_glitch(glitch_cycles);
        expect_no_ready(lead);
        fork
            u_line.send_frame(value);
            begin
                wait_for_ready(cycles);
                check_value("response.rdata", 64'(value), response.rdata);
                request = '0; // dropped in the ready cycle.
            end
        join
    endtask

    ready_one_cycle: assert property (
        @(posedge clock) disable iff (!reset)
        response.ready |=> !response.ready
    ) else report_failure("ready was high for more than one cycle");

    ready_needs_request: assert property (
        @(posedge clock) disable iff (!reset)
        response.ready |-> $past(request.valid)
    ) else report_failure("ready pulsed with no bus request present");

    quiet_after_reset: assert property (
        @(posedge clock) disable iff (!reset)
        !request_seen |-> (tx === uart_line_pkg::line_idle && !response.ready)
    ) else report_failure("tx or ready moved before the first request");

    rdata_zero_extended: assert property (
        @(posedge clock) disable iff (!reset)
        response.ready |-> (response.rdata[63:uart_line_pkg::data_bits] == '0)
    ) else report_failure("rdata upper bits not zero on ready");

    initial begin
        void'($urandom(32'hbc7a));
        request = '0;
        request_seen = 1'b0;
        reset = 1'b0;
        repeat (8) @(negedge clock);
        reset = 1'b1;
        expect_no_ready(3 * clks_per_bit);
        check_value("response.rdata", 64'd0, response.rdata);

        store_byte(8'($urandom), 1'b0);
        store_byte(8'($urandom), 1'b1); // presented in the cycle after ready.
        expect_no_ready(2 * clks_per_bit);

        load_byte(8'($urandom), 2 * clks_per_bit, 0);
        expect_no_ready(2 * clks_per_bit);

        // frame with no load pending is lost.
        dropped = 8'($urandom);
        kept = 8'($urandom);
        if (kept == dropped) kept = ~dropped;
        u_line.send_frame(dropped);
        expect_no_ready(3 * clks_per_bit);
        load_byte(kept, clks_per_bit, 0);
        expect_no_ready(2 * clks_per_bit);

        // pulse shorter than half a bit.
        load_byte(8'($urandom), 3 * clks_per_bit, clks_per_bit / 2 - 1);
        expect_no_ready(2 * clks_per_bit);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/uart_bus_pkg.sv
hdl/uart_line_pkg.sv
hdl/uart_bus_port.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/uart.sv
verification/uart_line_model.sv
verification/tb_uart.sv

// File: Bender.yml
package:
  name: uart

sources:
  - files:
      - hdl/uart_bus_pkg.sv
      - hdl/uart_line_pkg.sv
      - hdl/uart_bus_port.sv
      - hdl/uart_transmitter.sv
      - hdl/uart_receiver.sv
      - hdl/uart.sv
  - target: test
    files:
      - verification/uart_line_model.sv
      - verification/tb_uart.sv
